// File: logic/h2c_settings.svh
// Size settings for the host-to-card packet buffer
// Included by the package and by every block that sizes its own storage
`ifndef H2C_SETTINGS_SVH
`define H2C_SETTINGS_SVH

// Stream beat
`define H2C_DATA_BYTES     4
`define H2C_DATA_WIDTH     32
`define H2C_BYTE_IDX_W     2
`define H2C_USER_WIDTH     8

// Storage depths and index widths
`define H2C_BUF_DEPTH      16
`define H2C_BUF_PTR_W      4
`define H2C_DESC_DEPTH     4
`define H2C_DESC_PTR_W     2
`define H2C_OUT_FIFO_DEPTH 3
`define H2C_CNT_WIDTH      32
`endif

// File: logic/h2c_pkg.sv
// Vector types shared by the packet buffer blocks and the testbench
// Widths come from the settings header
`include "h2c_settings.svh"

package h2c_pkg;

   typedef logic [`H2C_DATA_WIDTH-1:0] data_t;
   typedef logic [`H2C_DATA_BYTES-1:0] keep_t;
   typedef logic [`H2C_USER_WIDTH-1:0] user_t;
   // Byte count minus one of a packet's last beat
   typedef logic [`H2C_BYTE_IDX_W-1:0] byte_idx_t;
   typedef logic [`H2C_BUF_PTR_W-1:0]  buf_idx_t;
   typedef logic [`H2C_CNT_WIDTH-1:0]  cnt_t;

endpackage

// File: logic/h2c_ingress.sv
// Producer side of the packet buffer
// Forwards every data-mover strobe as a beat write and pushes one
// descriptor per packet when the end-of-packet beat is written
`timescale 1ns/1ps

module h2c_ingress (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               dm_buf_wr,
   input  logic               dm_buf_eop,
   input  h2c_pkg::user_t     dm_buf_user,
   input  h2c_pkg::byte_idx_t dm_buf_num_bytes_minus1,
   input  h2c_pkg::buf_idx_t  wr_idx,
   input  logic               clr_in_pkt_cnt,
   output logic               beat_wr,
   output logic               desc_push,
   output h2c_pkg::buf_idx_t  desc_eop_idx,
   output h2c_pkg::byte_idx_t desc_nbytes_m1,
   output h2c_pkg::user_t     desc_user,
   output h2c_pkg::cnt_t      in_pkt_cnt
);
   assign beat_wr   = dm_buf_wr;
   assign desc_push = dm_buf_wr & dm_buf_eop;

   // Descriptor points at the slot the last beat is written to
   assign desc_eop_idx   = wr_idx;
   assign desc_nbytes_m1 = dm_buf_num_bytes_minus1;
   assign desc_user      = dm_buf_user;

   always_ff @(posedge clk) begin
      if (!rst_n)
         in_pkt_cnt <= '0;
      else if (clr_in_pkt_cnt)
         in_pkt_cnt <= '0;
      else if (desc_push)
         in_pkt_cnt <= in_pkt_cnt + 1'b1;
   end

endmodule

// File: logic/h2c_beat_buf.sv
// Beat storage of the packet buffer
// Simple dual-port RAM with wrap-bit write and read indices
// Read data is registered and follows rd_en by one cycle
`timescale 1ns/1ps
`include "h2c_settings.svh"

module h2c_beat_buf (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              beat_wr,
   input  h2c_pkg::data_t    wr_data,
   input  logic              rd_en,
   output h2c_pkg::buf_idx_t wr_idx,
   output h2c_pkg::buf_idx_t rd_idx,
   output h2c_pkg::data_t    rd_data,
   output logic              buf_full,
   output logic              buf_empty,
   output logic              buf_oflow
);
   localparam int DEPTH = `H2C_BUF_DEPTH;
   localparam h2c_pkg::buf_idx_t IDX_LAST = h2c_pkg::buf_idx_t'(DEPTH - 1);

   h2c_pkg::data_t    mem [DEPTH];
   logic              wr_wrap;
   logic              rd_wrap;
   logic              wr_ok;
   logic              wr_wrap_nxt;
   logic              rd_wrap_nxt;
   h2c_pkg::buf_idx_t wr_idx_nxt;
   h2c_pkg::buf_idx_t rd_idx_nxt;

   // A write while full is dropped
   assign wr_ok = beat_wr & ~buf_full;

   always_comb begin
      wr_wrap_nxt = wr_wrap;
      wr_idx_nxt  = wr_idx;
      rd_wrap_nxt = rd_wrap;
      rd_idx_nxt  = rd_idx;
      if (wr_ok) begin
         wr_wrap_nxt = wr_wrap ^ (wr_idx == IDX_LAST);
         wr_idx_nxt  = (wr_idx == IDX_LAST) ? '0 : wr_idx + 1'b1;
      end
      if (rd_en) begin
         rd_wrap_nxt = rd_wrap ^ (rd_idx == IDX_LAST);
         rd_idx_nxt  = (rd_idx == IDX_LAST) ? '0 : rd_idx + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_wrap   <= 1'b0;
         wr_idx    <= '0;
         rd_wrap   <= 1'b0;
         rd_idx    <= '0;
         buf_full  <= 1'b0;
         buf_empty <= 1'b1;
         buf_oflow <= 1'b0;
      end else begin
         wr_wrap   <= wr_wrap_nxt;
         wr_idx    <= wr_idx_nxt;
         rd_wrap   <= rd_wrap_nxt;
         rd_idx    <= rd_idx_nxt;
         buf_full  <= (wr_idx_nxt == rd_idx_nxt) & (wr_wrap_nxt != rd_wrap_nxt);
         buf_empty <= (wr_idx_nxt == rd_idx_nxt) & (wr_wrap_nxt == rd_wrap_nxt);
         buf_oflow <= beat_wr & buf_full;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_ok)
         mem[wr_idx] <= wr_data;
      if (rd_en)
         rd_data <= mem[rd_idx];
   end

endmodule

// File: logic/h2c_desc_fifo.sv
// Per-packet descriptor FIFO
// Small RAM with wrap-bit pointers feeding a flow-through output register,
// so the head descriptor stays visible until it is popped
`timescale 1ns/1ps
`include "h2c_settings.svh"

module h2c_desc_fifo (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               push,
   input  h2c_pkg::buf_idx_t  eop_idx,
   input  h2c_pkg::byte_idx_t nbytes_m1,
   input  h2c_pkg::user_t     user,
   input  logic               pop,
   output logic               valid,
   output h2c_pkg::buf_idx_t  out_eop_idx,
   output h2c_pkg::byte_idx_t out_nbytes_m1,
   output h2c_pkg::user_t     out_user,
   output logic               desc_full,
   output logic               desc_oflow
);
   localparam int DEPTH = `H2C_DESC_DEPTH;
   localparam int IDX_W = `H2C_DESC_PTR_W;
   localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(DEPTH - 1);

   h2c_pkg::buf_idx_t  ram_eop_idx [DEPTH];
   h2c_pkg::byte_idx_t ram_nbytes_m1 [DEPTH];
   h2c_pkg::user_t     ram_user [DEPTH];
   logic [IDX_W-1:0]   wr_idx;
   logic [IDX_W-1:0]   rd_idx;
   logic               wr_wrap;
   logic               rd_wrap;
   logic               ram_empty;
   logic               ram_full;
   logic               push_ok;
   logic               ram_pop;

   assign ram_empty = (wr_idx == rd_idx) & (wr_wrap == rd_wrap);
   assign ram_full  = (wr_idx == rd_idx) & (wr_wrap != rd_wrap);
   assign desc_full = ram_full;
   assign push_ok   = push & ~ram_full;
   // Refill the head register when it is empty or leaving this cycle
   assign ram_pop   = ~ram_empty & (~valid | pop);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_idx     <= '0;
         wr_wrap    <= 1'b0;
         rd_idx     <= '0;
         rd_wrap    <= 1'b0;
         valid      <= 1'b0;
         desc_oflow <= 1'b0;
      end else begin
         if (push_ok) begin
            wr_wrap <= wr_wrap ^ (wr_idx == IDX_LAST);
            wr_idx  <= (wr_idx == IDX_LAST) ? '0 : wr_idx + 1'b1;
         end
         if (ram_pop) begin
            rd_wrap <= rd_wrap ^ (rd_idx == IDX_LAST);
            rd_idx  <= (rd_idx == IDX_LAST) ? '0 : rd_idx + 1'b1;
         end
         if (ram_pop)
            valid <= 1'b1;
         else if (pop)
            valid <= 1'b0;
         desc_oflow <= push & ram_full;
      end
   end

   always_ff @(posedge clk) begin
      if (push_ok) begin
         ram_eop_idx[wr_idx]   <= eop_idx;
         ram_nbytes_m1[wr_idx] <= nbytes_m1;
         ram_user[wr_idx]      <= user;
      end
      if (ram_pop) begin
         out_eop_idx   <= ram_eop_idx[rd_idx];
         out_nbytes_m1 <= ram_nbytes_m1[rd_idx];
         out_user      <= ram_user[rd_idx];
      end
   end

endmodule

// File: logic/h2c_egress_pipe.sv
// Consumer pipeline of the packet buffer
// Stage 0 issues the RAM read, stage 1 takes the read data with a skid
// register behind it, stage 2 matches the head descriptor to set last/keep
// and feeds the output FIFO
`timescale 1ns/1ps
`include "h2c_settings.svh"

module h2c_egress_pipe (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               buf_empty,
   input  h2c_pkg::buf_idx_t  rd_idx,
   input  h2c_pkg::data_t     rd_data,
   input  logic               desc_valid,
   input  h2c_pkg::buf_idx_t  desc_eop_idx,
   input  h2c_pkg::byte_idx_t desc_nbytes_m1,
   input  h2c_pkg::user_t     desc_user,
   input  logic               stall,
   output logic               rd_en,
   output logic               desc_pop,
   output logic               out_push,
   output h2c_pkg::data_t     out_data,
   output h2c_pkg::keep_t     out_keep,
   output h2c_pkg::user_t     out_user,
   output logic               out_last
);
   logic              s0_valid;
   h2c_pkg::buf_idx_t s0_idx;
   logic              skid_valid;
   h2c_pkg::data_t    skid_data;
   h2c_pkg::buf_idx_t skid_idx;
   logic              s1_valid;
   h2c_pkg::data_t    s1_data;
   h2c_pkg::buf_idx_t s1_idx;
   logic              s1_go;
   logic              s1_eop;
   h2c_pkg::keep_t    last_keep;
   logic              s2_valid;

   // The user word only arrives with a packet's last beat, so a beat
   // waits in stage 1 until the head descriptor is there
   assign s1_go    = ~stall & (~s1_valid | desc_valid);
   assign rd_en    = ~buf_empty & s1_go;
   assign s1_eop   = desc_valid & (desc_eop_idx == s1_idx);
   assign desc_pop = s1_valid & s1_eop & s1_go;
   assign out_push = s2_valid & ~stall;

   // Low bytes up to the byte count of the last beat
   always_comb begin
      last_keep = '0;
      for (int i = 0; i < `H2C_DATA_BYTES; i++) begin
         if (i <= int'(desc_nbytes_m1))
            last_keep[i] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s0_valid   <= 1'b0;
         skid_valid <= 1'b0;
         s1_valid   <= 1'b0;
         s2_valid   <= 1'b0;
      end else begin
         s0_valid <= rd_en;
         // Catches the one read that was already issued when stage 1 stopped
         if (s0_valid & ~s1_go)
            skid_valid <= 1'b1;
         else if (s1_go)
            skid_valid <= 1'b0;
         if (s1_go)
            s1_valid <= s0_valid | skid_valid;
         if (!stall)
            s2_valid <= s1_valid & s1_go;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en)
         s0_idx <= rd_idx;
      if (s0_valid & ~s1_go) begin
         skid_data <= rd_data;
         skid_idx  <= s0_idx;
      end
      if (s1_go) begin
         s1_data  <= skid_valid ? skid_data : rd_data;
         s1_idx   <= skid_valid ? skid_idx : s0_idx;
         out_data <= s1_data;
         out_last <= s1_eop;
         out_keep <= s1_eop ? last_keep : '1;
         out_user <= desc_user;
      end
   end

endmodule

// File: logic/h2c_axis_out.sv
// Output FIFO of the packet buffer, first-word fall-through
// Drives the stream master and raises stall near full; also counts
// the packets that leave on the stream
`timescale 1ns/1ps
`include "h2c_settings.svh"

module h2c_axis_out (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           push,
   input  h2c_pkg::data_t push_data,
   input  h2c_pkg::keep_t push_keep,
   input  h2c_pkg::user_t push_user,
   input  logic           push_last,
   input  logic           axis_buf_ready,
   input  logic           clr_out_pkt_cnt,
   output logic           stall,
   output logic           buf_axis_valid,
   output h2c_pkg::data_t buf_axis_data,
   output h2c_pkg::keep_t buf_axis_keep,
   output h2c_pkg::user_t buf_axis_user,
   output logic           buf_axis_last,
   output h2c_pkg::cnt_t  out_pkt_cnt
);
   localparam int DEPTH = `H2C_OUT_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

   h2c_pkg::data_t   mem_data [DEPTH];
   h2c_pkg::keep_t   mem_keep [DEPTH];
   h2c_pkg::user_t   mem_user [DEPTH];
   logic             mem_last [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             pop;

   assign pop            = buf_axis_valid & axis_buf_ready;
   assign buf_axis_valid = (count != '0);
   assign buf_axis_data  = mem_data[rd_ptr];
   assign buf_axis_keep  = mem_keep[rd_ptr];
   assign buf_axis_user  = mem_user[rd_ptr];
   assign buf_axis_last  = mem_last[rd_ptr];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         stall       <= 1'b0;
         out_pkt_cnt <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
         if (push & ~pop)
            count <= count + 1'b1;
         else if (pop & ~push)
            count <= count - 1'b1;
         // Watermark from last cycle's occupancy, which leaves room for
         // the one push that can land before the pipe sees it
         stall <= (count >= CNT_W'(DEPTH - 1));
         if (clr_out_pkt_cnt)
            out_pkt_cnt <= '0;
         else if (pop & buf_axis_last)
            out_pkt_cnt <= out_pkt_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem_data[wr_ptr] <= push_data;
         mem_keep[wr_ptr] <= push_keep;
         mem_user[wr_ptr] <= push_user;
         mem_last[wr_ptr] <= push_last;
      end
   end

endmodule

// File: logic/h2c_buf_top.sv
// Host-to-card packet buffer top level
// Takes data-mover beat writes and replays them as a ready/valid stream
// with last and keep set on the final beat of each packet
`timescale 1ns/1ps

module h2c_buf_top (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                dm_buf_wr,
   input  h2c_pkg::data_t      dm_buf_data,
   input  logic                dm_buf_eop,
   input  h2c_pkg::user_t      dm_buf_user,
   input  h2c_pkg::byte_idx_t  dm_buf_num_bytes_minus1,
   input  logic                axis_buf_ready,
   input  logic                clr_in_pkt_cnt,
   input  logic                clr_out_pkt_cnt,
   output logic                buf_axis_valid,
   output h2c_pkg::data_t      buf_axis_data,
   output h2c_pkg::keep_t      buf_axis_keep,
   output h2c_pkg::user_t      buf_axis_user,
   output logic                buf_axis_last,
   output logic                buf_full,
   output logic                buf_empty,
   output logic                buf_oflow,
   output logic                desc_full,
   output logic                desc_oflow,
   output h2c_pkg::cnt_t       in_pkt_cnt,
   output h2c_pkg::cnt_t       out_pkt_cnt
);
   logic               beat_wr;
   logic               rd_en;
   h2c_pkg::buf_idx_t  wr_idx;
   h2c_pkg::buf_idx_t  rd_idx;
   h2c_pkg::data_t     rd_data;
   logic               desc_push;
   h2c_pkg::buf_idx_t  desc_eop_idx;
   h2c_pkg::byte_idx_t desc_nbytes_m1;
   h2c_pkg::user_t     desc_user;
   logic               desc_pop;
   logic               head_valid;
   h2c_pkg::buf_idx_t  head_eop_idx;
   h2c_pkg::byte_idx_t head_nbytes_m1;
   h2c_pkg::user_t     head_user;
   logic               out_push;
   h2c_pkg::data_t     out_data;
   h2c_pkg::keep_t     out_keep;
   h2c_pkg::user_t     out_user;
   logic               out_last;
   logic               stall;

   h2c_ingress u_ingress (
      .clk(clk), .rst_n(rst_n),
      .dm_buf_wr(dm_buf_wr), .dm_buf_eop(dm_buf_eop), .dm_buf_user(dm_buf_user),
      .dm_buf_num_bytes_minus1(dm_buf_num_bytes_minus1), .wr_idx(wr_idx),
      .clr_in_pkt_cnt(clr_in_pkt_cnt), .beat_wr(beat_wr), .desc_push(desc_push),
      .desc_eop_idx(desc_eop_idx), .desc_nbytes_m1(desc_nbytes_m1),
      .desc_user(desc_user), .in_pkt_cnt(in_pkt_cnt)
   );

   h2c_beat_buf u_beat_buf (
      .clk(clk), .rst_n(rst_n),
      .beat_wr(beat_wr), .wr_data(dm_buf_data), .rd_en(rd_en),
      .wr_idx(wr_idx), .rd_idx(rd_idx), .rd_data(rd_data),
      .buf_full(buf_full), .buf_empty(buf_empty), .buf_oflow(buf_oflow)
   );

   h2c_desc_fifo u_desc_fifo (
      .clk(clk), .rst_n(rst_n),
      .push(desc_push), .eop_idx(desc_eop_idx), .nbytes_m1(desc_nbytes_m1),
      .user(desc_user), .pop(desc_pop), .valid(head_valid),
      .out_eop_idx(head_eop_idx), .out_nbytes_m1(head_nbytes_m1), .out_user(head_user),
      .desc_full(desc_full), .desc_oflow(desc_oflow)
   );

   h2c_egress_pipe u_egress (
      .clk(clk), .rst_n(rst_n),
      .buf_empty(buf_empty), .rd_idx(rd_idx), .rd_data(rd_data),
      .desc_valid(head_valid), .desc_eop_idx(head_eop_idx),
      .desc_nbytes_m1(head_nbytes_m1), .desc_user(head_user), .stall(stall),
      .rd_en(rd_en), .desc_pop(desc_pop), .out_push(out_push), .out_data(out_data),
      .out_keep(out_keep), .out_user(out_user), .out_last(out_last)
   );

   h2c_axis_out u_axis_out (
      .clk(clk), .rst_n(rst_n),
      .push(out_push), .push_data(out_data), .push_keep(out_keep),
      .push_user(out_user), .push_last(out_last), .axis_buf_ready(axis_buf_ready),
      .clr_out_pkt_cnt(clr_out_pkt_cnt), .stall(stall), .buf_axis_valid(buf_axis_valid),
      .buf_axis_data(buf_axis_data), .buf_axis_keep(buf_axis_keep),
      .buf_axis_user(buf_axis_user), .buf_axis_last(buf_axis_last),
      .out_pkt_cnt(out_pkt_cnt)
   );

endmodule

// File: tests/h2c_buf_properties.sv
// Concurrent checks on the packet buffer top level
// Bound into h2c_buf_top by the bind statement at the end of this file
`timescale 1ns/1ps

module h2c_buf_properties (
   input logic           clk,
   input logic           rst_n,
   input logic           buf_axis_valid,
   input logic           axis_buf_ready,
   input h2c_pkg::data_t buf_axis_data,
   input h2c_pkg::keep_t buf_axis_keep,
   input h2c_pkg::user_t buf_axis_user,
   input logic           buf_axis_last,
   input logic           buf_full,
   input logic           buf_empty
);
   // Payload holds while the sink is not ready
   a_stream_stable: assert property (@(posedge clk) disable iff (!rst_n)
      buf_axis_valid && !axis_buf_ready |=> buf_axis_valid && $stable(buf_axis_data)
         && $stable(buf_axis_keep) && $stable(buf_axis_user) && $stable(buf_axis_last))
      else $error("stream output changed while the sink was not ready");

   // An empty buffer cannot turn full one write later
   a_full_empty: assert property (@(posedge clk) disable iff (!rst_n)
      buf_empty |=> !buf_full)
      else $error("buf_full rose straight out of an empty buffer");

   // Last beat keeps a run of low bytes, at least one of them
   a_last_keep: assert property (@(posedge clk) disable iff (!rst_n)
      buf_axis_valid && buf_axis_last |-> buf_axis_keep[0]
         && ((buf_axis_keep & (buf_axis_keep + h2c_pkg::keep_t'(1))) == '0))
      else $error("keep mask of a last beat is not a run of low bytes");

endmodule

bind h2c_buf_top h2c_buf_properties u_props (.*);

// File: tests/tb_clk_gen.sv
// Clock and reset source for the packet buffer testbench
// 4 ns clock; rst_n is low for the first two cycles and while rst_req is high
`timescale 1ns/1ps

module tb_clk_gen (
   input  logic rst_req,
   output logic clk,
   output logic rst_n
);
   logic por_n;

   initial begin
      clk   = 1'b0;
      por_n = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      por_n = 1'b1;
   end

   always #2 clk = ~clk;

   assign rst_n = por_n & ~rst_req;

endmodule

// File: tests/tb_h2c_buf.sv
// Testbench for the host-to-card packet buffer
// Plays a packet table with ready high and with random ready, checks the
// packet counters and their clears, then overfills the buffer and resets
`timescale 1ns/1ps

module tb_h2c_buf;
   localparam int NUM_ROWS = 8;
   localparam int TIMEOUT  = 2000;
   localparam int BEAT_W   = $bits(h2c_pkg::data_t) + $bits(h2c_pkg::keep_t)
                             + $bits(h2c_pkg::user_t) + 1;
   // One row per packet: beat count, bytes in the last beat, user word
   localparam int ROW_BEATS [NUM_ROWS] = '{1, 1, 1, 1, 2, 3, 5, 4};
   localparam int ROW_BYTES [NUM_ROWS] = '{1, 2, 3, 4, 4, 1, 2, 3};
   localparam h2c_pkg::user_t ROW_USER [NUM_ROWS] =
      '{8'h11, 8'h22, 8'h33, 8'h44, 8'h5a, 8'h6b, 8'h7c, 8'h8d};

   logic               clk;
   logic               rst_n;
   logic               rst_req;
   logic               dm_buf_wr;
   h2c_pkg::data_t     dm_buf_data;
   logic               dm_buf_eop;
   h2c_pkg::user_t     dm_buf_user;
   h2c_pkg::byte_idx_t dm_buf_num_bytes_minus1;
   logic               axis_buf_ready;
   logic               clr_in_pkt_cnt;
   logic               clr_out_pkt_cnt;
   logic               buf_axis_valid;
   h2c_pkg::data_t     buf_axis_data;
   h2c_pkg::keep_t     buf_axis_keep;
   h2c_pkg::user_t     buf_axis_user;
   logic               buf_axis_last;
   logic               buf_full;
   logic               buf_empty;
   logic               buf_oflow;
   logic               desc_full;
   logic               desc_oflow;
   h2c_pkg::cnt_t      in_pkt_cnt;
   h2c_pkg::cnt_t      out_pkt_cnt;

   // Ready mode: 0 held high, 1 random, 2 held low
   int                 ready_mode = 0;
   int                 err_cnt    = 0;
   int                 beat_cnt   = 0;
   int                 sent_pkts  = 0;
   // Expected beats as {data, keep, user, last}
   logic [BEAT_W-1:0]  exp_q [$];

   tb_clk_gen u_clk_gen (.rst_req(rst_req), .clk(clk), .rst_n(rst_n));

   h2c_buf_top u_dut (.*);

   always @(negedge clk) begin
      if (ready_mode == 0)
         axis_buf_ready = 1'b1;
      else if (ready_mode == 1)
         axis_buf_ready = ($urandom & 32'h1) != 0;
      else
         axis_buf_ready = 1'b0;
   end

   // Stream checker, one compare per transfer
   always @(posedge clk) begin
      if (rst_n && buf_axis_valid && axis_buf_ready) begin
         if (exp_q.size() == 0) begin
            err_cnt++;
            $display("FAIL %0t: unexpected beat, data %h", $time, buf_axis_data);
         end else begin
            if ({buf_axis_data, buf_axis_keep, buf_axis_user, buf_axis_last} !== exp_q[0]) begin
               err_cnt++;
               $display("FAIL %0t: beat %0d got %h/%b/%h/%b, expected %h", $time, beat_cnt,
                        buf_axis_data, buf_axis_keep, buf_axis_user, buf_axis_last, exp_q[0]);
            end
            void'(exp_q.pop_front());
         end
         beat_cnt++;
      end
   end

   function automatic h2c_pkg::keep_t keep_for_bytes(input int nbytes);
      return h2c_pkg::keep_t'((1 << nbytes) - 1);
   endfunction

   task automatic abort_on_timeout(input string what);
      $display("Timeout: %s", what);
      $display("Checked %0d beats, %0d errors, 1 timeout", beat_cnt, err_cnt);
      $display("Result: FAILED");
      $finish;
   endtask

   task automatic expect_val(input string what, input h2c_pkg::cnt_t got,
                             input h2c_pkg::cnt_t want);
      if (got !== want) begin
         err_cnt++;
         $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, want);
      end
   endtask

   task automatic check_reset_values();
      expect_val("buf_axis_valid", h2c_pkg::cnt_t'(buf_axis_valid), 0);
      expect_val("buf_empty", h2c_pkg::cnt_t'(buf_empty), 1);
      expect_val("buf_full", h2c_pkg::cnt_t'(buf_full), 0);
      expect_val("buf_oflow", h2c_pkg::cnt_t'(buf_oflow), 0);
      expect_val("desc_full", h2c_pkg::cnt_t'(desc_full), 0);
      expect_val("desc_oflow", h2c_pkg::cnt_t'(desc_oflow), 0);
      expect_val("in_pkt_cnt", in_pkt_cnt, 0);
      expect_val("out_pkt_cnt", out_pkt_cnt, 0);
   endtask

   // Writes one beat; with wait_room set it first waits for space like the data mover
   task automatic write_beat(input h2c_pkg::data_t d, input logic eop,
                             input h2c_pkg::byte_idx_t nb_m1, input h2c_pkg::user_t user,
                             input logic wait_room);
      int waited;
      waited = 0;
      while (wait_room && (buf_full || (eop && desc_full))) begin
         if (waited == TIMEOUT)
            abort_on_timeout("beat buffer or descriptor FIFO never freed up");
         @(negedge clk);
         waited++;
      end
      dm_buf_wr               = 1'b1;
      dm_buf_data             = d;
      dm_buf_eop              = eop;
      dm_buf_num_bytes_minus1 = nb_m1;
      dm_buf_user             = user;
      @(negedge clk);
      dm_buf_wr  = 1'b0;
      dm_buf_eop = 1'b0;
   endtask

   task automatic send_table();
      h2c_pkg::data_t d;
      logic           eop;
      for (int r = 0; r < NUM_ROWS; r++) begin
         for (int b = 0; b < ROW_BEATS[r]; b++) begin
            d   = $urandom;
            eop = (b == ROW_BEATS[r] - 1);
            exp_q.push_back({d, eop ? keep_for_bytes(ROW_BYTES[r]) : '1, ROW_USER[r], eop});
            write_beat(d, eop, h2c_pkg::byte_idx_t'(ROW_BYTES[r] - 1), ROW_USER[r], 1'b1);
         end
         sent_pkts++;
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         if (waited == TIMEOUT)
            abort_on_timeout("stream did not deliver all expected beats");
         @(negedge clk);
         waited++;
      end
   endtask

   task automatic wait_reset_release();
      int waited;
      waited = 0;
      while (!rst_n) begin
         if (waited == TIMEOUT)
            abort_on_timeout("reset was never released");
         @(negedge clk);
         waited++;
      end
   endtask

   initial begin
      logic           seen_full;
      logic           seen_oflow;
      h2c_pkg::data_t extra_data;
      void'($urandom(32'h70cffd21));
      rst_req                 = 1'b0;
      dm_buf_wr               = 1'b0;
      dm_buf_data             = '0;
      dm_buf_eop              = 1'b0;
      dm_buf_user             = '0;
      dm_buf_num_bytes_minus1 = '0;
      axis_buf_ready          = 1'b1;
      clr_in_pkt_cnt          = 1'b0;
      clr_out_pkt_cnt         = 1'b0;
      seen_full               = 1'b0;
      seen_oflow              = 1'b0;
      wait_reset_release();
      @(negedge clk);
      check_reset_values();

      // Table with the sink always ready, then with random ready
      send_table();
      wait_drain();
      expect_val("in_pkt_cnt", in_pkt_cnt, h2c_pkg::cnt_t'(sent_pkts));
      expect_val("out_pkt_cnt", out_pkt_cnt, h2c_pkg::cnt_t'(sent_pkts));
      ready_mode = 1;
      send_table();
      wait_drain();
      ready_mode = 0;
      expect_val("in_pkt_cnt", in_pkt_cnt, h2c_pkg::cnt_t'(sent_pkts));
      expect_val("out_pkt_cnt", out_pkt_cnt, h2c_pkg::cnt_t'(sent_pkts));

      // Each clear only touches its own counter
      clr_in_pkt_cnt = 1'b1;
      @(negedge clk);
      clr_in_pkt_cnt = 1'b0;
      expect_val("in_pkt_cnt after clear", in_pkt_cnt, 0);
      expect_val("out_pkt_cnt after in clear", out_pkt_cnt, h2c_pkg::cnt_t'(sent_pkts));
      // One more full-width packet so the input counter is nonzero again
      extra_data = $urandom;
      exp_q.push_back({extra_data, keep_for_bytes(4), ROW_USER[0], 1'b1});
      write_beat(extra_data, 1'b1, h2c_pkg::byte_idx_t'(3), ROW_USER[0], 1'b1);
      sent_pkts++;
      wait_drain();
      expect_val("in_pkt_cnt after one packet", in_pkt_cnt, 1);
      expect_val("out_pkt_cnt after one packet", out_pkt_cnt, h2c_pkg::cnt_t'(sent_pkts));
      clr_out_pkt_cnt = 1'b1;
      @(negedge clk);
      clr_out_pkt_cnt = 1'b0;
      expect_val("out_pkt_cnt after clear", out_pkt_cnt, 0);
      expect_val("in_pkt_cnt after out clear", in_pkt_cnt, 1);

      // 24 beats against a stopped sink, more than buffer and pipe can hold
      ready_mode = 2;
      @(negedge clk);
      for (int i = 0; i < 24; i++) begin
         write_beat($urandom, (i % 8) == 7, h2c_pkg::byte_idx_t'(3), 8'ha5, 1'b0);
         if (buf_full)
            seen_full = 1'b1;
         if (buf_oflow)
            seen_oflow = 1'b1;
      end
      if (!seen_full) begin
         err_cnt++;
         $display("FAIL %0t: buf_full never rose during the overfill", $time);
      end
      if (!seen_oflow) begin
         err_cnt++;
         $display("FAIL %0t: buf_oflow never pulsed during the overfill", $time);
      end
      rst_req = 1'b1;
      repeat (2) @(negedge clk);
      rst_req = 1'b0;
      wait_reset_release();
      @(negedge clk);
      check_reset_values();

      $display("Checked %0d beats, %0d errors", beat_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// File: sim.f
+incdir+logic
logic/h2c_pkg.sv
logic/h2c_ingress.sv
logic/h2c_beat_buf.sv
logic/h2c_desc_fifo.sv
logic/h2c_egress_pipe.sv
logic/h2c_axis_out.sv
logic/h2c_buf_top.sv
tests/h2c_buf_properties.sv
tests/tb_clk_gen.sv
tests/tb_h2c_buf.sv

// File: Makefile
# Verilator build and run for the host-to-card packet buffer
VERILATOR  := verilator
TOP        := tb_h2c_buf
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Fails unless the run prints the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
